// ==== common/l2_cache_pkg.sv ====
`default_nettype none

package l2_cache_pkg;

	////////////////////
	// cache organisation
	////////////////////

	// byte offset inside a 16-byte line
	localparam int OFFSET_W = 4;

	// byte address from either L1 or the tag port
	typedef logic [31:0] addr_t;

	// one full cache line
	typedef logic [127:0] line_t;

	////////////////////
	// tag register image
	////////////////////

	// valid and dirty on top, tag right-aligned, zero in between
	typedef logic [31:0] tag_lo_t;

	localparam int TAG_LO_VALID = 31;
	localparam int TAG_LO_DIRTY = 30;

endpackage

`default_nettype wire

// ==== common/l2_bus_pkg.sv ====
`default_nettype none

package l2_bus_pkg;

	// which requester owns the current transaction
	typedef logic [1:0] src_t;

	localparam src_t SRC_NONE = 2'd0;
	localparam src_t SRC_D    = 2'd1;
	localparam src_t SRC_I    = 2'd2;
	localparam src_t SRC_OP   = 2'd3;

	////////////////////
	// requester buses
	////////////////////

	typedef struct packed {
		logic                rd;
		logic                wr;
		l2_cache_pkg::addr_t addr;
		l2_cache_pkg::line_t wdata;
	} d_req_t;

	typedef struct packed {
		logic                rd;
		l2_cache_pkg::addr_t addr;
	} i_req_t;

	// index load tag / index store tag
	typedef struct packed {
		logic                  ld_tag;
		logic                  st_tag;
		l2_cache_pkg::addr_t   index;
		l2_cache_pkg::tag_lo_t tag_lo;
	} op_req_t;

	typedef struct packed {
		logic                rd;
		logic                wr;
		l2_cache_pkg::addr_t addr;
		l2_cache_pkg::line_t wdata;
	} mem_req_t;

	// controller to datapath
	typedef struct packed {
		src_t src;
		logic tag_we;
		logic valid_val;
		logic dirty_val;
		logic data_we;
		logic data_from_d;
		logic fwd_mem;
		logic mem_victim;
	} dp_sel_t;

endpackage

`default_nettype wire

// ==== l2_cache/l2_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_ctrl (
	input  logic                clk,
	input  logic                i_arst_n,
	input  l2_bus_pkg::src_t    i_src,
	input  logic                i_d_wr,
	input  logic                i_hit,
	input  logic                i_valid,
	input  logic                i_dirty,
	input  logic                i_mem_ready,
	output logic                o_capture,
	output l2_bus_pkg::dp_sel_t o_sel,
	output logic                o_mem_rd,
	output logic                o_mem_wr,
	output logic                o_ready_d,
	output logic                o_ready_i,
	output logic                o_ready_op,
	output logic                o_tag_w
);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		COMPARE,
		WRITEBACK,
		REFILL,
		RESPOND,
		DONE
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   is_op;
	logic   finish;

	assign is_op = (i_src == l2_bus_pkg::SRC_OP);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (i_src != l2_bus_pkg::SRC_NONE) begin
					state_nxt = LOOKUP;
				end
			end
			// arrays read the latched index
			LOOKUP: state_nxt = COMPARE;
			COMPARE: begin
				if (is_op || i_hit) begin
					state_nxt = RESPOND;
				end else if (i_valid && i_dirty) begin
					state_nxt = WRITEBACK;
				end else begin
					state_nxt = REFILL;
				end
			end
			WRITEBACK: begin
				if (i_mem_ready) begin
					state_nxt = REFILL;
				end
			end
			REFILL: begin
				if (i_mem_ready) begin
					state_nxt = DONE;
				end
			end
			RESPOND: state_nxt = DONE;
			// one spare cycle so a held level is dropped
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	////////////////////
	// strobes
	////////////////////

	// ready goes out on a hit / tag op, or with the refill data
	assign finish = (state == RESPOND) || (state == REFILL && i_mem_ready);

	assign o_capture  = (state == IDLE);
	assign o_mem_rd   = (state == REFILL);
	assign o_mem_wr   = (state == WRITEBACK);
	assign o_ready_d  = finish && (i_src == l2_bus_pkg::SRC_D);
	assign o_ready_i  = finish && (i_src == l2_bus_pkg::SRC_I);
	assign o_ready_op = finish && is_op;

	// load tag hands the image to the tag register
	assign o_tag_w = (state == RESPOND) && is_op && !i_d_wr;

	always_comb begin
		o_sel            = '0;
		o_sel.src        = i_src;
		o_sel.mem_victim = (state == WRITEBACK);
		if (state == RESPOND && i_d_wr) begin
			// store tag or dcache write hit
			o_sel.tag_we      = 1'b1;
			o_sel.valid_val   = 1'b1;
			o_sel.dirty_val   = 1'b1;
			o_sel.data_we     = !is_op;
			o_sel.data_from_d = 1'b1;
		end else if (state == REFILL && i_mem_ready) begin
			// write miss keeps the dcache line, read miss takes memory
			o_sel.tag_we      = 1'b1;
			o_sel.valid_val   = 1'b1;
			o_sel.dirty_val   = i_d_wr;
			o_sel.data_we     = 1'b1;
			o_sel.data_from_d = i_d_wr;
			o_sel.fwd_mem     = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== l2_cache/l2_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_tag_array #(
	parameter int INDEX_W = 10
) (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic [INDEX_W-1:0]    i_index,
	input  logic [31-INDEX_W-l2_cache_pkg::OFFSET_W:0] i_req_tag,
	input  l2_bus_pkg::dp_sel_t   i_sel,
	input  l2_cache_pkg::tag_lo_t i_op_tag_lo,
	output logic                  o_hit,
	output logic                  o_valid,
	output logic                  o_dirty,
	output l2_cache_pkg::tag_lo_t o_tag_lo,
	output l2_cache_pkg::addr_t   o_victim_addr
);

	localparam int OFF_W = l2_cache_pkg::OFFSET_W;
	localparam int TAG_W = 32 - INDEX_W - OFF_W;
	localparam int DEPTH = 2 ** INDEX_W;

	logic [DEPTH-1:0] valid_vec;
	logic [DEPTH-1:0] dirty_vec;
	logic [TAG_W-1:0] tag_mem [DEPTH];
	logic [TAG_W-1:0] tag_q;
	logic             valid_q;
	logic             dirty_q;
	logic [TAG_W-1:0] wr_tag;
	logic             wr_valid;
	logic             wr_dirty;

	// store tag takes everything from the op tag register
	always_comb begin
		if (i_sel.src == l2_bus_pkg::SRC_OP) begin
			wr_tag   = i_op_tag_lo[TAG_W-1:0];
			wr_valid = i_op_tag_lo[l2_cache_pkg::TAG_LO_VALID];
			wr_dirty = i_op_tag_lo[l2_cache_pkg::TAG_LO_DIRTY];
		end else begin
			wr_tag   = i_req_tag;
			wr_valid = i_sel.valid_val;
			wr_dirty = i_sel.dirty_val;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_vec <= '0;
			dirty_vec <= '0;
			valid_q   <= 1'b0;
			dirty_q   <= 1'b0;
		end else begin
			if (i_sel.tag_we) begin
				valid_vec[i_index] <= wr_valid;
				dirty_vec[i_index] <= wr_dirty;
			end
			valid_q <= valid_vec[i_index];
			dirty_q <= dirty_vec[i_index];
		end
	end

	always_ff @(posedge clk) begin
		if (i_sel.tag_we) begin
			tag_mem[i_index] <= wr_tag;
		end
		tag_q <= tag_mem[i_index];
	end

	assign o_hit         = valid_q && (tag_q == i_req_tag);
	assign o_valid       = valid_q;
	assign o_dirty       = dirty_q;
	assign o_victim_addr = {tag_q, i_index, {OFF_W{1'b0}}};

	// tag field only shown for a valid line
	always_comb begin
		o_tag_lo                             = '0;
		o_tag_lo[l2_cache_pkg::TAG_LO_VALID] = valid_q;
		o_tag_lo[l2_cache_pkg::TAG_LO_DIRTY] = dirty_q;
		if (valid_q) begin
			o_tag_lo[TAG_W-1:0] = tag_q;
		end
	end

endmodule

`default_nettype wire

// ==== l2_cache/l2_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_data_array #(
	parameter int INDEX_W = 10
) (
	input  logic                clk,
	input  logic [INDEX_W-1:0]  i_index,
	input  l2_bus_pkg::dp_sel_t i_sel,
	input  l2_cache_pkg::line_t i_wline,
	input  l2_cache_pkg::line_t i_mem_data,
	output l2_cache_pkg::line_t o_line,
	output l2_cache_pkg::line_t o_rd_data
);

	localparam int DEPTH = 2 ** INDEX_W;

	l2_cache_pkg::line_t line_mem [DEPTH];
	l2_cache_pkg::line_t line_q;
	l2_cache_pkg::line_t wr_line;

	// whole-line merge from dcache, else refill from memory
	assign wr_line = i_sel.data_from_d ? i_wline : i_mem_data;

	always_ff @(posedge clk) begin
		if (i_sel.data_we) begin
			line_mem[i_index] <= wr_line;
		end
		line_q <= line_mem[i_index];
	end

	// victim line for writeback
	assign o_line = line_q;

	// refill data goes straight out with ready
	assign o_rd_data = i_sel.fwd_mem ? i_mem_data : line_q;

endmodule

`default_nettype wire

// ==== verilog/l2_req_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_req_latch #(
	parameter int INDEX_W = 10
) (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_capture,
	input  l2_bus_pkg::d_req_t    i_dreq,
	input  l2_bus_pkg::i_req_t    i_ireq,
	input  l2_bus_pkg::op_req_t   i_op,
	output l2_bus_pkg::src_t      o_src,
	output logic [INDEX_W-1:0]    o_index,
	output logic [31-INDEX_W-l2_cache_pkg::OFFSET_W:0] o_req_tag,
	output l2_cache_pkg::addr_t   o_req_addr,
	output l2_cache_pkg::line_t   o_wline,
	output l2_cache_pkg::tag_lo_t o_op_tag_lo,
	output logic                  o_d_wr
);

	localparam int OFF_W = l2_cache_pkg::OFFSET_W;
	localparam int TAG_W = 32 - INDEX_W - OFF_W;

	l2_bus_pkg::d_req_t  dreq_q;
	l2_bus_pkg::i_req_t  ireq_q;
	l2_bus_pkg::op_req_t op_q;
	l2_bus_pkg::src_t    src_now;
	l2_bus_pkg::src_t    src_q;
	l2_cache_pkg::addr_t sel_addr;

	// op first, then dcache, then icache
	always_comb begin
		if (i_op.ld_tag || i_op.st_tag) begin
			src_now = l2_bus_pkg::SRC_OP;
		end else if (i_dreq.rd || i_dreq.wr) begin
			src_now = l2_bus_pkg::SRC_D;
		end else if (i_ireq.rd) begin
			src_now = l2_bus_pkg::SRC_I;
		end else begin
			src_now = l2_bus_pkg::SRC_NONE;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			src_q <= l2_bus_pkg::SRC_NONE;
		end else if (i_capture) begin
			src_q <= src_now;
		end
	end

	always_ff @(posedge clk) begin
		if (i_capture) begin
			dreq_q <= i_dreq;
			ireq_q <= i_ireq;
			op_q   <= i_op;
		end
	end

	// live winner while idle, frozen one after
	assign o_src = i_capture ? src_now : src_q;

	always_comb begin
		case (src_q)
			l2_bus_pkg::SRC_OP: sel_addr = op_q.index;
			l2_bus_pkg::SRC_I:  sel_addr = ireq_q.addr;
			default:            sel_addr = dreq_q.addr;
		endcase
	end

	assign o_index     = sel_addr[OFF_W +: INDEX_W];
	assign o_req_tag   = sel_addr[OFF_W+INDEX_W +: TAG_W];
	assign o_req_addr  = {sel_addr[31:OFF_W], {OFF_W{1'b0}}};
	assign o_wline     = dreq_q.wdata;
	assign o_op_tag_lo = op_q.tag_lo;

	// write flavour of the active request, dcache write or store tag
	assign o_d_wr = (src_q == l2_bus_pkg::SRC_D)  ? dreq_q.wr :
	                (src_q == l2_bus_pkg::SRC_OP) ? op_q.st_tag : 1'b0;

endmodule

`default_nettype wire

// ==== verilog/l2_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_top #(
	parameter int INDEX_W = 10
) (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  l2_bus_pkg::d_req_t    i_dreq,
	input  l2_bus_pkg::i_req_t    i_ireq,
	input  l2_bus_pkg::op_req_t   i_op,
	output l2_bus_pkg::mem_req_t  o_mem,
	input  logic                  i_mem_ready,
	input  l2_cache_pkg::line_t   i_mem_data,
	output l2_cache_pkg::line_t   o_rd_data,
	output l2_cache_pkg::tag_lo_t o_tag_lo,
	output logic                  o_tag_w,
	output logic                  o_ready_d,
	output logic                  o_ready_i,
	output logic                  o_ready_op
);

	localparam int TAG_W = 32 - INDEX_W - l2_cache_pkg::OFFSET_W;

	l2_bus_pkg::src_t      src;
	l2_bus_pkg::dp_sel_t   sel;
	logic                  capture;
	logic                  d_wr;
	logic [INDEX_W-1:0]    index;
	logic [TAG_W-1:0]      req_tag;
	l2_cache_pkg::addr_t   req_addr;
	l2_cache_pkg::addr_t   victim_addr;
	l2_cache_pkg::line_t   wline;
	l2_cache_pkg::line_t   victim_line;
	l2_cache_pkg::tag_lo_t op_tag_lo;
	logic                  hit;
	logic                  valid;
	logic                  dirty;
	logic                  mem_rd;
	logic                  mem_wr;

	l2_req_latch #(
		.INDEX_W(INDEX_W)
	) u_latch (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_capture  (capture),
		.i_dreq     (i_dreq),
		.i_ireq     (i_ireq),
		.i_op       (i_op),
		.o_src      (src),
		.o_index    (index),
		.o_req_tag  (req_tag),
		.o_req_addr (req_addr),
		.o_wline    (wline),
		.o_op_tag_lo(op_tag_lo),
		.o_d_wr     (d_wr)
	);

	l2_ctrl u_ctrl (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_src      (src),
		.i_d_wr     (d_wr),
		.i_hit      (hit),
		.i_valid    (valid),
		.i_dirty    (dirty),
		.i_mem_ready(i_mem_ready),
		.o_capture  (capture),
		.o_sel      (sel),
		.o_mem_rd   (mem_rd),
		.o_mem_wr   (mem_wr),
		.o_ready_d  (o_ready_d),
		.o_ready_i  (o_ready_i),
		.o_ready_op (o_ready_op),
		.o_tag_w    (o_tag_w)
	);

	l2_tag_array #(
		.INDEX_W(INDEX_W)
	) u_tag (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_index      (index),
		.i_req_tag    (req_tag),
		.i_sel        (sel),
		.i_op_tag_lo  (op_tag_lo),
		.o_hit        (hit),
		.o_valid      (valid),
		.o_dirty      (dirty),
		.o_tag_lo     (o_tag_lo),
		.o_victim_addr(victim_addr)
	);

	l2_data_array #(
		.INDEX_W(INDEX_W)
	) u_data (
		.clk       (clk),
		.i_index   (index),
		.i_sel     (sel),
		.i_wline   (wline),
		.i_mem_data(i_mem_data),
		.o_line    (victim_line),
		.o_rd_data (o_rd_data)
	);

	// writeback goes to the victim, refill to the request line
	always_comb begin
		o_mem.rd    = mem_rd;
		o_mem.wr    = mem_wr;
		o_mem.addr  = sel.mem_victim ? victim_addr : req_addr;
		o_mem.wdata = victim_line;
	end

endmodule

`default_nettype wire

// ==== test/l2_top_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_top_chk (
	input logic                 clk,
	input logic                 i_arst_n,
	input l2_bus_pkg::mem_req_t o_mem,
	input logic                 i_mem_ready,
	input logic                 o_tag_w,
	input logic                 o_ready_d,
	input logic                 o_ready_i,
	input logic                 o_ready_op
);

	a_one_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0({o_ready_d, o_ready_i, o_ready_op}))
		else $error("more than one ready at once");

	a_mem_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
		!(o_mem.rd && o_mem.wr))
		else $error("memory read and write together");

	// address held until the memory answers
	a_addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
		(o_mem.rd || o_mem.wr) && !i_mem_ready |=> $stable(o_mem.addr))
		else $error("memory address changed while waiting");

	a_tag_w: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_tag_w |-> o_ready_op)
		else $error("tag write without op ready");

endmodule

bind l2_top l2_top_chk u_chk (
	.clk        (clk),
	.i_arst_n   (i_arst_n),
	.o_mem      (o_mem),
	.i_mem_ready(i_mem_ready),
	.o_tag_w    (o_tag_w),
	.o_ready_d  (o_ready_d),
	.o_ready_i  (o_ready_i),
	.o_ready_op (o_ready_op)
);

`default_nettype wire

// ==== test/tb_l2_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_l2_top;

	logic                  clk;
	logic                  i_arst_n;
	l2_bus_pkg::d_req_t    i_dreq;
	l2_bus_pkg::i_req_t    i_ireq;
	l2_bus_pkg::op_req_t   i_op;
	l2_bus_pkg::mem_req_t  o_mem;
	logic                  i_mem_ready;
	l2_cache_pkg::line_t   i_mem_data;
	l2_cache_pkg::line_t   o_rd_data;
	l2_cache_pkg::tag_lo_t o_tag_lo;
	logic                  o_tag_w;
	logic                  o_ready_d;
	logic                  o_ready_i;
	logic                  o_ready_op;

	// command table from the stim file
	logic [63:0]  k_q[$];
	logic [31:0]  a_q[$];
	logic [127:0] d_q[$];
	logic [127:0] e_q[$];
	int           l_q[$];

	// memory model state
	logic [127:0] mem_store [logic [31:0]];
	logic [31:0]  lcg_state;
	logic         mem_busy;
	int           mem_cnt;

	int cycles;
	int limit;

	l2_top #(
		.INDEX_W(4)
	) uut (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_dreq     (i_dreq),
		.i_ireq     (i_ireq),
		.i_op       (i_op),
		.o_mem      (o_mem),
		.i_mem_ready(i_mem_ready),
		.i_mem_data (i_mem_data),
		.o_rd_data  (o_rd_data),
		.o_tag_lo   (o_tag_lo),
		.o_tag_w    (o_tag_w),
		.o_ready_d  (o_ready_d),
		.o_ready_i  (o_ready_i),
		.o_ready_op (o_ready_op)
	);

	always #20 clk = ~clk;

	////////////////////
	// helpers
	////////////////////

	function automatic int lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]);
	endfunction

	// unwritten lines hold their line address four times
	function automatic logic [127:0] mem_line(input logic [31:0] addr);
		logic [31:0] la;
		la = {addr[31:4], 4'h0};
		if (mem_store.exists(la)) begin
			return mem_store[la];
		end
		return {la, la, la, la};
	endfunction

	task automatic fail_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		if (exp !== act) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	// ready bits ordered {dcache, icache, op}
	function automatic logic [2:0] ready_of(input int idx);
		if (k_q[idx] == "D_RD" || k_q[idx] == "D_WR") begin
			return 3'b100;
		end else if (k_q[idx] == "I_RD") begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	task automatic drive_req(input int idx, input logic on);
		if (k_q[idx] == "D_RD") begin
			i_dreq.rd   = on;
			i_dreq.addr = a_q[idx];
		end else if (k_q[idx] == "D_WR") begin
			i_dreq.wr    = on;
			i_dreq.addr  = a_q[idx];
			i_dreq.wdata = d_q[idx];
		end else if (k_q[idx] == "I_RD") begin
			i_ireq.rd   = on;
			i_ireq.addr = a_q[idx];
		end else if (k_q[idx] == "LD_TAG") begin
			i_op.ld_tag = on;
			i_op.index  = a_q[idx];
		end else if (k_q[idx] == "ST_TAG") begin
			i_op.st_tag = on;
			i_op.index  = a_q[idx];
			i_op.tag_lo = d_q[idx][31:0];
		end else begin
			$display("Unknown command kind in the stim file at entry %0d", idx);
			fail_run();
		end
	endtask

	// samples mid low phase, edges counts rising edges passed
	task automatic wait_any_ready(output logic [2:0] rv, inout int edges);
		rv = 3'b000;
		while (rv == 3'b000) begin
			@(negedge clk);
			edges++;
			#10;
			rv = {o_ready_d, o_ready_i, o_ready_op};
		end
	endtask

	task automatic check_result(input int idx, input logic [2:0] rv, input int edges);
		string name;
		name = $sformatf("cmd%0d %0s %h", idx, k_q[idx], a_q[idx]);
		check_value({name, " ready"}, 128'(ready_of(idx)), 128'(rv));
		if (k_q[idx] == "D_RD" || k_q[idx] == "I_RD") begin
			check_value({name, " data"}, e_q[idx], o_rd_data);
		end
		if (k_q[idx] == "LD_TAG") begin
			check_value({name, " tag"}, e_q[idx], 128'(o_tag_lo));
		end
		// tag register load only on index load tag
		check_value({name, " tag_w"}, 128'(k_q[idx] == "LD_TAG"), 128'(o_tag_w));
		if (l_q[idx] > 0) begin
			check_value({name, " latency"}, 128'(l_q[idx]), 128'(edges));
		end
	endtask

	// entered and left on a falling edge with the controller idle
	task automatic run_single(input int idx);
		logic [2:0] rv;
		int         edges;
		edges = 0;
		drive_req(idx, 1'b1);
		wait_any_ready(rv, edges);
		check_result(idx, rv, edges);
		@(negedge clk);
		drive_req(idx, 1'b0);
		@(negedge clk);
	endtask

	// three requests held at once, served in file order
	task automatic run_group(input int idx);
		logic [2:0] rv;
		int         edges;
		edges = 0;
		for (int j = 1; j <= 3; j++) begin
			drive_req(idx + j, 1'b1);
		end
		for (int j = 1; j <= 3; j++) begin
			wait_any_ready(rv, edges);
			check_result(idx + j, rv, edges);
			@(negedge clk);
			drive_req(idx + j, 1'b0);
			edges = 1;
		end
		@(negedge clk);
	endtask

	task automatic read_stim();
		int          fd;
		int          r;
		string       line;
		logic [63:0] kind;
		logic [31:0] addr;
		logic [127:0] data;
		logic [127:0] exp;
		int          lat;
		fd = $fopen("test/l2_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stim file test/l2_stim.txt");
			fail_run();
		end
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			r = $sscanf(line, "%s %h %h %h %d", kind, addr, data, exp, lat);
			if (r == 5) begin
				k_q.push_back(kind);
				a_q.push_back(addr);
				d_q.push_back(data);
				e_q.push_back(exp);
				l_q.push_back(lat);
			end
		end
		$fclose(fd);
	endtask

	////////////////////
	// memory model
	////////////////////

	always @(negedge clk) begin
		if (!i_arst_n) begin
			i_mem_ready = 1'b0;
			mem_busy    = 1'b0;
		end else if (i_mem_ready) begin
			i_mem_ready = 1'b0;
		end else if (o_mem.rd || o_mem.wr) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_cnt  = 1 + (lcg_next() % 8);
			end
			if (mem_cnt == 1) begin
				mem_busy    = 1'b0;
				i_mem_ready = 1'b1;
				if (o_mem.wr) begin
					mem_store[o_mem.addr] = o_mem.wdata;
				end else begin
					i_mem_data = mem_line(o_mem.addr);
				end
			end else begin
				mem_cnt--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			fail_run();
		end
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int idx;
		clk         = 1'b0;
		i_arst_n    = 1'b0;
		i_dreq      = '0;
		i_ireq      = '0;
		i_op        = '0;
		i_mem_ready = 1'b0;
		i_mem_data  = '0;
		lcg_state   = 32'd27964;
		mem_busy    = 1'b0;
		mem_cnt     = 0;
		cycles      = 0;
		limit       = 0;
		read_stim();
		// worst case of writeback plus refill fits in 30 cycles
		limit = k_q.size() * 30 + 10;
		repeat (5) @(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);
		idx = 0;
		while (idx < k_q.size()) begin
			if (k_q[idx] == "PRIO") begin
				run_group(idx);
				idx = idx + 4;
			end else begin
				run_single(idx);
				idx = idx + 1;
			end
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/l2_stim.txt ====
# kind address data_or_tag expected_line_or_tag latency (0 = not checked)
# PRIO issues the next three commands together, listed in priority order
I_RD 00000100 0 00000100000001000000010000000100 0
I_RD 00000104 0 00000100000001000000010000000100 3
D_WR 00000210 11112222333344445555666677778888 0 0
D_RD 00000210 0 11112222333344445555666677778888 3
D_RD 00000310 0 00000310000003100000031000000310 0
D_RD 00000210 0 11112222333344445555666677778888 0
D_WR 00000520 AAAAAAAABBBBBBBBCCCCCCCCDDDDDDDD 0 0
LD_TAG 00000020 0 C0000005 3
LD_TAG 000000F0 0 00000000 3
ST_TAG 00000000 00000000 0 3
LD_TAG 00000000 0 00000000 3
I_RD 00000100 0 00000100000001000000010000000100 0
PRIO 0 0 0 0
LD_TAG 00000020 0 C0000005 3
D_RD 00000520 0 AAAAAAAABBBBBBBBCCCCCCCCDDDDDDDD 0
I_RD 00000100 0 00000100000001000000010000000100 0

// ==== filelist.f ====
common/l2_cache_pkg.sv
common/l2_bus_pkg.sv
l2_cache/l2_ctrl.sv
l2_cache/l2_tag_array.sv
l2_cache/l2_data_array.sv
verilog/l2_req_latch.sv
verilog/l2_top.sv
test/l2_top_chk.sv
test/tb_l2_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_l2_top -f filelist.f
output=$(./obj_dir/Vtb_l2_top 2>&1) || true
echo "$output"
if echo "$output" | grep -q "^Test OK$"; then
	exit 0
else
	exit 1
fi
